/* design/trace_pkg.sv */
// Record fields follow the APB word layout. The tag field is 8 bits, so ID_W must not exceed 8.
`default_nettype none

package trace_pkg;

    ////////////////////////////////////////
    // Stage value and retirement record.
    ////////////////////////////////////////

    localparam int VAL_W = 16;                  // Width of every stage value.

    typedef logic [VAL_W-1:0] val_t;

    // Order matches REC0, REC1 and REC2 from the top down.
    typedef struct packed {
        val_t       pc;                         // Written by fetch.
        val_t       instr;                      // Written by decode.
        val_t       result;                     // Written by execute.
        val_t       addr;                       // Written by memory.
        val_t       data;                       // Taken live from write-back.
        logic [7:0] tag;                        // Zero extended instruction tag.
        logic [6:0] stall_cycles;               // Decode stall count, saturating.
        logic       halt;                       // Instruction was the halt.
    } retire_rec_t;

    ////////////////////////////////////////
    // APB register map, byte offsets.
    ////////////////////////////////////////

    localparam logic [4:0] STATUS_ADDR = 5'h00; // Not empty, level, done.
    localparam logic [4:0] DROP_ADDR   = 5'h04; // Dropped record count.
    localparam logic [4:0] REC0_ADDR   = 5'h08; // pc and instr.
    localparam logic [4:0] REC1_ADDR   = 5'h0C; // result and addr.
    localparam logic [4:0] REC2_ADDR   = 5'h10; // data, tag, stalls, halt. Read pops.
    localparam logic [4:0] CTRL_ADDR   = 5'h14; // Bit 0 clears the drop count.

endpackage

`default_nettype wire

/* design/stage_if.sv */
// Carries no clock. Every signal is a register output of the tracker.
`timescale 1ns/1ns
`default_nettype none

interface stage_if #(
    parameter int ID_W = 4                      // Tag width.
);

    // Per stage valids.
    logic            fetch_v;
    logic            decode_v;
    logic            exec_v;
    logic            mem_v;
    logic            wb_v;

    // Per stage tags.
    logic [ID_W-1:0] fetch_tag;
    logic [ID_W-1:0] decode_tag;
    logic [ID_W-1:0] exec_tag;
    logic [ID_W-1:0] mem_tag;
    logic [ID_W-1:0] wb_tag;

    logic            stall_q;                   // Stall of the previous edge.
    logic            halt_seen;                 // Sticky once a halt left decode.

    modport tracker (
        output fetch_v, decode_v, exec_v, mem_v, wb_v,
        output fetch_tag, decode_tag, exec_tag, mem_tag, wb_tag,
        output stall_q, halt_seen
    );

    modport store (
        input fetch_v, decode_v, exec_v, mem_v, wb_v,
        input fetch_tag, decode_tag, exec_tag, mem_tag, wb_tag,
        input stall_q, halt_seen
    );

endinterface

`default_nettype wire

/* design/stage_tracker.sv */
// hlt counts only with decode valid and no stall. After a halt, fetch stays off until reset.
`timescale 1ns/1ns
`default_nettype none

module stage_tracker #(
    parameter int ID_W = 4                      // Tag width, 2^ID_W tags in flight.
) (
    input  logic             clk,
    input  logic             rst_n,             // Synchronous, active low.
    input  logic             stall,             // Freezes fetch and decode.
    input  logic             hlt,               // Instruction in decode is a halt.
    stage_if.tracker         stages
);

    logic halt_now;                             // Halt accepted at this edge.

    // A halt is taken once, when decode moves on.
    assign halt_now = stages.decode_v & ~stall & hlt & ~stages.halt_seen;

    ////////////////////////////////////////
    // Stage shift.
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stages.fetch_v    <= 1'b0;
            stages.decode_v   <= 1'b0;
            stages.exec_v     <= 1'b0;
            stages.mem_v      <= 1'b0;
            stages.wb_v       <= 1'b0;
            stages.fetch_tag  <= '0;
            stages.decode_tag <= '0;
            stages.exec_tag   <= '0;
            stages.mem_tag    <= '0;
            stages.wb_tag     <= '0;
            stages.stall_q    <= 1'b0;
            stages.halt_seen  <= 1'b0;
        end else begin
            stages.stall_q <= stall;            // Record store counts on this.

            if (halt_now) begin
                stages.halt_seen <= 1'b1;       // Sticky until reset.
            end

            // Memory and write-back never stall.
            stages.mem_v   <= stages.exec_v;
            stages.mem_tag <= stages.exec_tag;
            stages.wb_v    <= stages.mem_v;
            stages.wb_tag  <= stages.mem_tag;

            if (stall) begin
                // Fetch and decode hold.
                stages.exec_v <= 1'b0;          // Bubble into execute.
            end else begin
                // Tag counter lives in the fetch tag itself.
                stages.fetch_tag <= stages.fetch_tag + ID_W'(stages.fetch_v);
                stages.fetch_v   <= ~(stages.halt_seen | halt_now);

                // The instruction behind a halt is discarded here.
                stages.decode_v   <= stages.fetch_v & ~halt_now;
                stages.decode_tag <= stages.fetch_tag;

                stages.exec_v   <= stages.decode_v;
                stages.exec_tag <= stages.decode_tag;
            end
        end
    end

endmodule

`default_nettype wire

/* design/record_store.sv */
// ID_W at most 8. Stall cycles count decode stalls only. The record is combinational on write-back.
`timescale 1ns/1ns
`default_nettype none

module record_store #(
    parameter int ID_W = 4                      // Tag width, sets the slot count.
) (
    input  logic                   clk,
    input  logic                   rst_n,
    stage_if.store                 stages,
    input  trace_pkg::val_t        fetch_pc,
    input  trace_pkg::val_t        decode_instr,
    input  trace_pkg::val_t        ex_result,
    input  trace_pkg::val_t        mem_addr,
    input  trace_pkg::val_t        wb_data,
    input  logic                   hlt,
    output trace_pkg::retire_rec_t rec,
    output logic                   push
);

    localparam int SLOTS = 1 << ID_W;

    ////////////////////////////////////////
    // Slot storage.
    ////////////////////////////////////////

    trace_pkg::val_t pc_mem     [SLOTS];
    trace_pkg::val_t instr_mem  [SLOTS];
    trace_pkg::val_t result_mem [SLOTS];
    trace_pkg::val_t addr_mem   [SLOTS];
    logic [6:0]      stall_cnt  [SLOTS];        // Decode stall cycles.
    logic            halt_flag  [SLOTS];

    // Stage payloads, one tag per stage per edge.
    always_ff @(posedge clk) begin
        if (stages.fetch_v) begin
            pc_mem[stages.fetch_tag] <= fetch_pc;
        end
        if (stages.decode_v) begin
            instr_mem[stages.decode_tag] <= decode_instr;
        end
        if (stages.exec_v) begin
            result_mem[stages.exec_tag] <= ex_result;
        end
        if (stages.mem_v) begin
            addr_mem[stages.mem_tag] <= mem_addr;
        end
    end

    // Stall count and halt flag per slot.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < SLOTS; i++) begin
                stall_cnt[i] <= '0;
                halt_flag[i] <= 1'b0;
            end
        end else begin
            if (stages.fetch_v) begin
                stall_cnt[stages.fetch_tag] <= '0;      // Fresh slot.
            end
            if (stages.decode_v) begin
                halt_flag[stages.decode_tag] <= hlt;    // Last write before leaving wins.
                // stall_q high means decode held this same instruction.
                if (stages.stall_q && stall_cnt[stages.decode_tag] != 7'h7F) begin
                    stall_cnt[stages.decode_tag] <= stall_cnt[stages.decode_tag] + 7'd1;
                end
            end
        end
    end

    ////////////////////////////////////////
    // Retirement record.
    ////////////////////////////////////////

    always_comb begin
        rec              = '0;
        rec.pc           = pc_mem[stages.wb_tag];
        rec.instr        = instr_mem[stages.wb_tag];
        rec.result       = result_mem[stages.wb_tag];
        rec.addr         = addr_mem[stages.wb_tag];
        rec.data         = wb_data;              // Live write-back value.
        rec.tag[ID_W-1:0] = stages.wb_tag;       // Upper tag bits stay zero.
        rec.stall_cycles = stall_cnt[stages.wb_tag];
        rec.halt         = halt_flag[stages.wb_tag];
    end

    assign push = stages.wb_v;                  // One pulse per retiring instruction.

endmodule

`default_nettype wire

/* design/retire_fifo.sv */
// FIFO_DEPTH is a power of two from 2 to 8. A push into a full FIFO is dropped even with a pop.
`timescale 1ns/1ns
`default_nettype none

module retire_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   push,
    input  trace_pkg::retire_rec_t rec_in,
    input  logic                   pop,
    input  logic                   drop_clr,    // Clear wins over a drop.
    output trace_pkg::retire_rec_t head,
    output logic                   empty,
    output logic [3:0]             level,
    output logic [15:0]            drops
);

    localparam int PTR_W = $clog2(FIFO_DEPTH);

    trace_pkg::retire_rec_t mem [FIFO_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [3:0]             count;
    logic                   full;
    logic                   do_push;
    logic                   do_pop;

    assign full    = (count == 4'(FIFO_DEPTH));
    assign empty   = (count == 4'd0);
    assign do_push = push & ~full;
    assign do_pop  = pop & ~empty;              // Pop of empty is ignored.

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= rec_in;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
            drops  <= '0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(do_push);     // Wraps at the depth.
            rd_ptr <= rd_ptr + PTR_W'(do_pop);
            count  <= count + 4'(do_push) - 4'(do_pop);
            if (drop_clr) begin
                drops <= '0;
            end else if (push && full && drops != 16'hFFFF) begin
                drops <= drops + 16'd1;             // Saturates.
            end
        end
    end

    assign head  = mem[rd_ptr];
    assign level = count;

endmodule

`default_nettype wire

/* design/apb_trace_regs.sv */
// No wait states. Read data is captured in the setup phase, so STATUS shows that cycle's state.
`timescale 1ns/1ns
`default_nettype none

module apb_trace_regs (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   psel,
    input  logic                   penable,
    input  logic                   pwrite,
    input  logic [4:0]             paddr,
    input  logic [31:0]            pwdata,
    output logic [31:0]            prdata,
    output logic                   pready,
    output logic                   pslverr,
    input  trace_pkg::retire_rec_t head,
    input  logic                   empty,
    input  logic [3:0]             level,
    input  logic [15:0]            drops,
    input  logic                   done,        // Halt seen and pipeline empty.
    output logic                   pop,
    output logic                   drop_clr
);

    logic        setup;
    logic        access;
    logic        mapped;
    logic [31:0] rd_word;
    logic        pop_ok_q;                      // REC2 read of a non-empty FIFO.

    assign setup  = psel & ~penable;
    assign access = psel & penable;

    ////////////////////////////////////////
    // Address decode and read mux.
    ////////////////////////////////////////

    always_comb begin
        mapped  = 1'b1;
        rd_word = '0;
        case (paddr)
            trace_pkg::STATUS_ADDR: rd_word = {23'd0, done, level, 3'd0, ~empty};
            trace_pkg::DROP_ADDR:   rd_word = {16'd0, drops};
            trace_pkg::REC0_ADDR:   rd_word = empty ? '0 : {head.pc, head.instr};
            trace_pkg::REC1_ADDR:   rd_word = empty ? '0 : {head.result, head.addr};
            trace_pkg::REC2_ADDR: begin
                if (!empty) begin
                    rd_word = {head.data, head.tag, head.stall_cycles, head.halt};
                end
            end
            trace_pkg::CTRL_ADDR:   rd_word = '0;           // Write only.
            default:                mapped  = 1'b0;
        endcase
    end

    // Head cannot change between setup and access, only a pop moves it.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            prdata   <= '0;
            pop_ok_q <= 1'b0;
        end else if (setup) begin
            prdata   <= pwrite ? '0 : rd_word;
            pop_ok_q <= ~pwrite & ~empty & (paddr == trace_pkg::REC2_ADDR);
        end
    end

    ////////////////////////////////////////
    // Access phase outputs.
    ////////////////////////////////////////

    assign pready   = 1'b1;
    assign pslverr  = access & ~mapped;
    assign pop      = access & pop_ok_q;        // Head leaves after the read.
    assign drop_clr = access & pwrite & (paddr == trace_pkg::CTRL_ADDR) & pwdata[0];

endmodule

`default_nettype wire

/* design/pipe_trace_top.sv */
// No back-pressure to the CPU. Records that meet a full FIFO are dropped and counted. ID_W at most 8.
`timescale 1ns/1ns
`default_nettype none

module pipe_trace_top #(
    parameter int ID_W       = 4,               // Tag width.
    parameter int FIFO_DEPTH = 8                // Power of two, at most 8.
) (
    input  logic            clk,
    input  logic            rst_n,
    // CPU side.
    input  logic            stall,
    input  logic            hlt,
    input  trace_pkg::val_t fetch_pc,
    input  trace_pkg::val_t decode_instr,
    input  trace_pkg::val_t ex_result,
    input  trace_pkg::val_t mem_addr,
    input  trace_pkg::val_t wb_data,
    // APB side.
    input  logic            psel,
    input  logic            penable,
    input  logic            pwrite,
    input  logic [4:0]      paddr,
    input  logic [31:0]     pwdata,
    output logic [31:0]     prdata,
    output logic            pready,
    output logic            pslverr
);

    stage_if #(.ID_W(ID_W)) stages ();

    trace_pkg::retire_rec_t rec;                // Store to FIFO.
    trace_pkg::retire_rec_t head;               // FIFO to APB.
    logic                   push;
    logic                   pop;
    logic                   drop_clr;
    logic                   empty;
    logic                   done;
    logic [3:0]             level;
    logic [15:0]            drops;

    // Done once the halt has drained out of every stage.
    assign done = stages.halt_seen & ~(stages.fetch_v | stages.decode_v | stages.exec_v |
                                       stages.mem_v | stages.wb_v);

    stage_tracker #(.ID_W(ID_W)) u_tracker (
        .clk, .rst_n, .stall, .hlt,
        .stages (stages.tracker)
    );

    record_store #(.ID_W(ID_W)) u_store (
        .clk, .rst_n,
        .stages (stages.store),
        .fetch_pc, .decode_instr, .ex_result, .mem_addr, .wb_data, .hlt,
        .rec, .push
    );

    retire_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
        .clk, .rst_n, .push,
        .rec_in (rec),
        .pop, .drop_clr, .head, .empty, .level, .drops
    );

    apb_trace_regs u_apb (
        .clk, .rst_n, .psel, .penable, .pwrite, .paddr, .pwdata,
        .prdata, .pready, .pslverr,
        .head, .empty, .level, .drops, .done, .pop, .drop_clr
    );

endmodule

`default_nettype wire

/* dv/trace_tests.svh */
// Included at the end of tb_pipe_trace. Every test starts from reset and uses the model there.
`ifndef TRACE_TESTS_SVH
`define TRACE_TESTS_SVH

////////////////////////////////////////
// Record and register helpers.
////////////////////////////////////////

// The REC2 read pops the head.
task automatic pull_record(output trace_pkg::retire_rec_t rec);
    logic [31:0] w0;
    logic [31:0] w1;
    logic [31:0] w2;
    logic        e0;
    logic        e1;
    logic        e2;
    apb_read(trace_pkg::REC0_ADDR, w0, e0);
    apb_read(trace_pkg::REC1_ADDR, w1, e1);
    apb_read(trace_pkg::REC2_ADDR, w2, e2);
    check_flag("pslverr", e0 | e1 | e2, 1'b0);
    rec = trace_pkg::retire_rec_t'({w0, w1, w2});   // Word order matches the record.
endtask

task automatic compare_next();
    trace_pkg::retire_rec_t got;
    pull_record(got);
    if (expect_q.size() == 0) begin
        errors++;
        $display("A record was read while the model expected no more");
    end else begin
        check_rec("rec", got, expect_q.pop_front());
    end
endtask

task automatic expect_reg(input string name, input logic [4:0] addr,
                          input logic [31:0] exp);
    logic [31:0] data;
    logic        err;
    apb_read(addr, data, err);
    check_word(name, data, exp);
    check_flag("pslverr", err, 1'b0);
endtask

////////////////////////////////////////
// Directed tests.
////////////////////////////////////////

task automatic test_straight();
    reset_dut();
    run_insns(6, -1, 0);
    repeat (6) compare_next();                      // Tags 0 to 5 and no stalls.
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);
endtask

task automatic test_stall();
    reset_dut();
    run_insns(6, 2, 3);                             // Seq 2 held in decode 3 cycles.
    repeat (6) compare_next();
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);   // No extra record.
endtask

task automatic test_halt();
    reset_dut();
    halt_seq = 4;
    while (!(m_halt && !m_fv && !m_dv && !m_ev && !m_mv && !m_wv)) begin
        clock_cpu(1'b0);
    end
    repeat (5) compare_next();                      // Seq 4 carries the halt.
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0100);   // Done and empty.
endtask

task automatic test_overflow();
    reset_dut();
    run_insns(FIFO_DEPTH + 3, -1, 0);
    expect_reg("status", trace_pkg::STATUS_ADDR, {24'd0, 4'(FIFO_DEPTH), 4'h1});
    expect_reg("drops", trace_pkg::DROP_ADDR, 32'd3);
    repeat (FIFO_DEPTH) compare_next();
    expect_q.delete();                              // The last three were dropped.
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);
    apb_write(trace_pkg::CTRL_ADDR, 32'h0000_0001);
    expect_reg("drops", trace_pkg::DROP_ADDR, 32'd0);
endtask

task automatic test_apb_edges();
    logic [31:0] data;
    logic        err;
    reset_dut();
    apb_read(5'h18, data, err);                     // Past the map.
    check_flag("pslverr", err, 1'b1);
    apb_read(5'h1C, data, err);
    check_flag("pslverr", err, 1'b1);
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);
    expect_reg("rec0", trace_pkg::REC0_ADDR, 32'h0000_0000);
    expect_reg("rec2", trace_pkg::REC2_ADDR, 32'h0000_0000);    // Pop of empty.
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);
    run_insns(2, -1, 0);
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0021);
    compare_next();
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0011);
    compare_next();
    expect_reg("status", trace_pkg::STATUS_ADDR, 32'h0000_0000);
endtask

`endif

/* dv/tb_pipe_trace.sv */
// Each test resets the DUT, the only way to clear a halt. Stage values come from a TB shift model.
`timescale 1ns/1ns
`default_nettype none

module tb_pipe_trace;

    localparam int ID_W       = 4;
    localparam int FIFO_DEPTH = 8;
    localparam int MAX_SEQ    = 64;                 // Sequence numbers per test.
    localparam int TEST_SUM   = 60 + 65 + 55 + 85 + 45;  // Rough cycles per test.
    localparam int TIMEOUT    = 3 * TEST_SUM;

    logic            clk;
    logic            rst_n;
    logic            stall;
    logic            hlt;
    trace_pkg::val_t fetch_pc;
    trace_pkg::val_t decode_instr;
    trace_pkg::val_t ex_result;
    trace_pkg::val_t mem_addr;
    trace_pkg::val_t wb_data;
    logic            psel;
    logic            penable;
    logic            pwrite;
    logic [4:0]      paddr;
    logic [31:0]     pwdata;
    logic [31:0]     prdata;
    logic            pready;
    logic            pslverr;

    integer seed;                                   // $random state.
    int     errors;
    int     checks;
    int     cycles;

    ////////////////////////////////////////
    // CPU model, state after the last edge.
    ////////////////////////////////////////

    trace_pkg::val_t        instr_tab [MAX_SEQ];    // Instruction word per seq.
    int                     scnt      [MAX_SEQ];    // Expected decode stalls per seq.
    logic                   m_fv;
    logic                   m_dv;
    logic                   m_ev;
    logic                   m_mv;
    logic                   m_wv;
    int                     m_fseq;
    int                     m_dseq;
    int                     m_eseq;
    int                     m_mseq;
    int                     m_wseq;
    logic                   m_halt;                 // Halt taken, fetch is off.
    int                     halt_seq;               // Seq of the halt, -1 for none.
    trace_pkg::retire_rec_t expect_q [$];           // Records in retirement order.

    pipe_trace_top #(.ID_W(ID_W), .FIFO_DEPTH(FIFO_DEPTH)) UUT (
        .clk, .rst_n, .stall, .hlt,
        .fetch_pc, .decode_instr, .ex_result, .mem_addr, .wb_data,
        .psel, .penable, .pwrite, .paddr, .pwdata, .prdata, .pready, .pslverr
    );

    always #5 clk = ~clk;                           // 10 ns period.

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles > TIMEOUT) begin
            $display("Timeout: no result after %0d cycles", TIMEOUT);
            $display("tests failed");
            $finish;
        end
    end

    ////////////////////////////////////////
    // Compare tasks.
    ////////////////////////////////////////

    task automatic check_rec(input string name, input trace_pkg::retire_rec_t got,
                             input trace_pkg::retire_rec_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h, expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // CPU driver.
    ////////////////////////////////////////

    // Values of the instruction that sits in each stage.
    task automatic drive_stages();
        fetch_pc     = 16'(4 * m_fseq);
        decode_instr = instr_tab[m_dseq];
        ex_result    = instr_tab[m_eseq] ^ 16'h5A5A;
        mem_addr     = 16'(4 * m_mseq) + 16'h0100;
        wb_data      = (instr_tab[m_wseq] ^ 16'h5A5A) + 16'd1;
    endtask

    function automatic trace_pkg::retire_rec_t expected_rec(input int seq);
        trace_pkg::retire_rec_t r;
        r.pc           = 16'(4 * seq);
        r.instr        = instr_tab[seq];
        r.result       = r.instr ^ 16'h5A5A;
        r.addr         = r.pc + 16'h0100;
        r.data         = r.result + 16'd1;
        r.tag          = 8'(seq % (1 << ID_W));     // Tags wrap at 2^ID_W.
        r.stall_cycles = 7'(scnt[seq]);
        r.halt         = (seq == halt_seq);
        return r;
    endfunction

    // One clock with the given stall. Starts and ends 1 ns after an edge.
    task automatic clock_cpu(input logic st);
        logic h;
        logic taken;
        h     = m_dv && (m_dseq == halt_seq);       // Halt instruction in decode.
        stall = st;
        hlt   = h;
        @(posedge clk);
        if (m_wv) begin
            expect_q.push_back(expected_rec(m_wseq));   // Pushed at this edge.
        end
        if (st && m_dv) begin
            scnt[m_dseq] = scnt[m_dseq] + 1;
        end
        taken  = m_dv && !st && h && !m_halt;
        m_wv   = m_mv;
        m_wseq = m_mseq;
        m_mv   = m_ev;
        m_mseq = m_eseq;
        if (st) begin
            m_ev = 1'b0;                            // Bubble.
        end else begin
            m_ev   = m_dv;
            m_eseq = m_dseq;
            m_dv   = m_fv && !taken;                // Fetch behind a halt is lost.
            m_dseq = m_fseq;
            m_fseq = m_fseq + (m_fv ? 1 : 0);
            m_fv   = !(m_halt || taken);
        end
        if (taken) begin
            m_halt = 1'b1;
        end
        #1;
        drive_stages();
    endtask

    // Runs until seq n reaches decode, then stalls there and drains the rest.
    task automatic run_insns(input int n, input int hold_seq, input int hold_len);
        int   left;
        logic st;
        left = hold_len;
        while (!(m_dv && m_dseq == n)) begin
            st = m_dv && (m_dseq == hold_seq) && (left > 0);
            if (st) begin
                left = left - 1;
            end
            clock_cpu(st);
        end
        clock_cpu(1'b1);
        while (m_ev || m_mv || m_wv) begin
            clock_cpu(1'b1);
        end
    endtask

    task automatic reset_dut();
        rst_n    = 1'b0;
        stall    = 1'b1;                            // Pipeline stays empty until a run.
        hlt      = 1'b0;
        psel     = 1'b0;
        penable  = 1'b0;
        pwrite   = 1'b0;
        paddr    = '0;
        pwdata   = '0;
        m_fv     = 1'b0;
        m_dv     = 1'b0;
        m_ev     = 1'b0;
        m_mv     = 1'b0;
        m_wv     = 1'b0;
        m_fseq   = 0;
        m_dseq   = 0;
        m_eseq   = 0;
        m_mseq   = 0;
        m_wseq   = 0;
        m_halt   = 1'b0;
        halt_seq = -1;
        for (int i = 0; i < MAX_SEQ; i++) begin
            scnt[i] = 0;
        end
        expect_q.delete();
        drive_stages();
        repeat (5) @(posedge clk);
        #1;
        rst_n = 1'b1;
    endtask

    ////////////////////////////////////////
    // APB master.
    ////////////////////////////////////////

    task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
                            output logic err);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = addr;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(negedge clk);                             // Mid access cycle.
        data = prdata;
        err  = pslverr;
        check_flag("pready", pready, 1'b1);
        @(posedge clk);
        #1;
        psel    = 1'b0;
        penable = 1'b0;
    endtask

    task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
        psel    = 1'b1;
        penable = 1'b0;
        pwrite  = 1'b1;
        paddr   = addr;
        pwdata  = data;
        @(posedge clk);
        #1;
        penable = 1'b1;
        @(posedge clk);                             // Write takes effect here.
        #1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    initial begin
        seed    = 56;
        errors  = 0;
        checks  = 0;
        cycles  = 0;
        clk     = 1'b0;
        for (int i = 0; i < MAX_SEQ; i++) begin
            instr_tab[i] = 16'($random(seed));
        end
        reset_dut();
        test_straight();
        test_stall();
        test_halt();
        test_overflow();
        test_apb_edges();
        $display("Summary: %0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    `include "trace_tests.svh"

endmodule

`default_nettype wire

/* tb.f */
+incdir+dv
design/trace_pkg.sv
design/stage_if.sv
design/stage_tracker.sv
design/record_store.sv
design/retire_fifo.sv
design/apb_trace_regs.sv
design/pipe_trace_top.sv
dv/tb_pipe_trace.sv
